/* verilog/dm_cfg.svh */
`ifndef DM_CFG_SVH
`define DM_CFG_SVH

// ==============================
// memory geometry
// ==============================

// number of 32-bit words in the data memory
`define DM_WORDS 3072

// word index width, enough to address every word
`define DM_IDX_W 12

// ==============================
// legal byte address window
// ==============================

// first legal byte address
`define DM_ADDR_LB 32'h0000_0000

// last legal byte address, the top byte of the top word
`define DM_ADDR_UB ((`DM_WORDS * 4) - 1)

// ==============================
// access mode codes
// ==============================

// no access at all, always accepted
`define DM_NONE 3'd0
// full word
`define DM_W 3'd1
// signed halfword
`define DM_H 3'd2
// unsigned halfword
`define DM_HU 3'd3
// signed byte
`define DM_B 3'd4
// unsigned byte
`define DM_BU 3'd5

`endif

/* verilog/dm_pkg.sv */
`include "dm_cfg.svh"

package dm_pkg;

	// ==============================
	// access mode
	// ==============================

	// enum literals follow the mode macros one to one
	typedef enum logic [2:0] {
		mode_none = `DM_NONE,
		mode_w    = `DM_W,
		mode_h    = `DM_H,
		mode_hu   = `DM_HU,
		mode_b    = `DM_B,
		mode_bu   = `DM_BU
	} dm_mode_e;

	// ==============================
	// request and response
	// ==============================

	// one request from the pipeline, 68 bits
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        we;
		dm_mode_e    mode;
	} dm_req_t;

	// one response, load data plus the check result, 33 bits
	typedef struct packed {
		logic [31:0] rdata;
		logic        ok;
	} dm_resp_t;

	// ==============================
	// internal transfers
	// ==============================

	// one block RAM access
	// be has one bit per byte lane, lane 0 is bits 7:0
	typedef struct packed {
		logic [`DM_IDX_W-1:0] idx;
		logic [3:0]           be;
		logic [31:0]          wdata;
	} dm_ram_req_t;

	// what the load side needs to know in the read cycle
	typedef struct packed {
		dm_mode_e   mode;
		logic [1:0] offset;
		logic       ok;
	} dm_lane_t;

endpackage

/* verilog/dm_access_check.sv */
`timescale 1ns/100ps
`include "dm_cfg.svh"

module dm_access_check (
	input  logic                clk,
	input  logic                rst,
	input  dm_pkg::dm_req_t     req,
	input  logic                req_valid,
	output dm_pkg::dm_ram_req_t ram_req,
	output logic                ram_en,
	output dm_pkg::dm_lane_t    tag,
	output logic                tag_valid
);
	import dm_pkg::*;

	// address lies inside the memory window
	logic in_window;
	// address meets the alignment rule of its mode
	logic aligned;
	// access is legal
	logic ok;
	// byte offset inside the addressed word
	logic [1:0] offset;
	// a legal store in this cycle
	logic do_write;
	// per-lane write enables
	logic [3:0] be;
	// store data moved into the selected lanes
	logic [31:0] lane_wdata;

	// ==============================
	// window and alignment check
	// ==============================

	assign offset = req.addr[1:0];

	// unsigned compare against both ends of the window
	assign in_window = (req.addr >= `DM_ADDR_LB) && (req.addr <= `DM_ADDR_UB);

	always_comb begin
		case (req.mode)
			// word needs both low bits clear
			mode_w: aligned = (offset == 2'b00);
			// halfword needs an even address
			mode_h, mode_hu: aligned = ~offset[0];
			// bytes fit anywhere
			mode_b, mode_bu: aligned = 1'b1;
			// none and unused codes
			default: aligned = 1'b0;
		endcase
	end

	// mode none is always fine, even outside the window
	assign ok = (req.mode == mode_none) || (in_window && aligned);

	// ==============================
	// byte enables and store data
	// ==============================

	// unsigned modes never store
	assign do_write = req_valid && ok && req.we;

	always_comb begin
		be = 4'b0000;
		lane_wdata = req.wdata;
		if (do_write) begin
			case (req.mode)
				mode_w: begin
					be = 4'b1111;
				end
				mode_h: begin
					// addr bit 1 picks the lower or upper pair
					be = offset[1] ? 4'b1100 : 4'b0011;
					lane_wdata = req.wdata << {offset[1], 4'b0000};
				end
				mode_b: begin
					// one lane, shifted by eight per offset step
					be = 4'b0001 << offset;
					lane_wdata = req.wdata << {offset, 3'b000};
				end
				default: begin
					be = 4'b0000;
				end
			endcase
		end
	end

	// out of window requests read word zero, the load side drops the data
	assign ram_req.idx   = in_window ? req.addr[`DM_IDX_W+1:2] : '0;
	assign ram_req.be    = be;
	assign ram_req.wdata = lane_wdata;

	// the RAM runs on every strobe, be decides whether anything is written
	assign ram_en = req_valid;

	// ==============================
	// lane tag for the read cycle
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			tag_valid <= 1'b0;
		end else begin
			tag_valid <= req_valid;
		end
	end

	// tag payload, only loaded on a strobe
	always_ff @(posedge clk) begin
		if (req_valid) begin
			tag.mode   <= req.mode;
			tag.offset <= offset;
			tag.ok     <= ok;
		end
	end

endmodule

/* verilog/dm_ram.sv */
`timescale 1ns/100ps
`include "dm_cfg.svh"

module dm_ram (
	input  logic                clk,
	input  dm_pkg::dm_ram_req_t ram_req,
	input  logic                ram_en,
	output logic [31:0]         rword
);

	// word-wide storage, one block RAM
	logic [31:0] mem [`DM_WORDS];

	// ==============================
	// power-up contents
	// ==============================

	// block RAM starts out zero, reset leaves it alone
	initial begin
		for (int i = 0; i < `DM_WORDS; i++) begin
			mem[i] = 32'h0000_0000;
		end
	end

	// ==============================
	// write port
	// ==============================

	// each lane is written on its own enable
	always @(posedge clk) begin
		if (ram_en) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (ram_req.be[lane]) begin
					mem[ram_req.idx][8*lane +: 8] <= ram_req.wdata[8*lane +: 8];
				end
			end
		end
	end

	// ==============================
	// read port
	// ==============================

	// read first, a store returns the word as it was before the edge
	// rword is valid one cycle after the request edge
	always_ff @(posedge clk) begin
		if (ram_en) begin
			rword <= mem[ram_req.idx];
		end
	end

endmodule

/* verilog/dm_load_align.sv */
`timescale 1ns/100ps

module dm_load_align (
	input  logic             rst,
	input  logic [31:0]      rword,
	input  dm_pkg::dm_lane_t tag,
	input  logic             tag_valid,
	output dm_pkg::dm_resp_t resp,
	output logic             resp_valid
);
	import dm_pkg::*;

	// halfword named by offset bit 1
	logic [15:0] lane_h;
	// byte named by the full offset
	logic [7:0] lane_b;
	// extended load result before the ok gate
	logic [31:0] ext_data;

	// ==============================
	// lane select
	// ==============================

	assign lane_h = tag.offset[1] ? rword[31:16] : rword[15:0];

	always_comb begin
		case (tag.offset)
			2'b00: lane_b = rword[7:0];
			2'b01: lane_b = rword[15:8];
			2'b10: lane_b = rword[23:16];
			default: lane_b = rword[31:24];
		endcase
	end

	// ==============================
	// sign or zero extension
	// ==============================

	always_comb begin
		case (tag.mode)
			mode_w: ext_data = rword;
			// sign bit replicated into the upper half
			mode_h: ext_data = {{16{lane_h[15]}}, lane_h};
			mode_hu: ext_data = {16'h0000, lane_h};
			// sign bit replicated into the upper three bytes
			mode_b: ext_data = {{24{lane_b[7]}}, lane_b};
			mode_bu: ext_data = {24'h00_0000, lane_b};
			// mode none returns zero
			default: ext_data = 32'h0000_0000;
		endcase
	end

	// ==============================
	// response
	// ==============================

	// failed checks give zero data
	assign resp.rdata = tag.ok ? ext_data : 32'h0000_0000;
	assign resp.ok    = tag.ok;

	// held low while reset is asserted
	assign resp_valid = tag_valid && !rst;

endmodule

/* verilog/dm.sv */
`timescale 1ns/100ps

module dm (
	input  logic             clk,
	input  logic             rst,
	input  dm_pkg::dm_req_t  req,
	input  logic             req_valid,
	output dm_pkg::dm_resp_t resp,
	output logic             resp_valid
);
	import dm_pkg::*;

	// check stage to RAM
	dm_ram_req_t ram_req;
	logic        ram_en;

	// check stage to load side, one cycle late
	dm_lane_t tag;
	logic     tag_valid;

	// RAM read word, lines up with tag
	logic [31:0] rword;

	// ==============================
	// request cycle
	// ==============================

	// window, alignment, byte enables
	dm_access_check u_check (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.req_valid (req_valid),
		.ram_req   (ram_req),
		.ram_en    (ram_en),
		.tag       (tag),
		.tag_valid (tag_valid)
	);

	// read-first byte-enabled storage
	dm_ram u_ram (
		.clk     (clk),
		.ram_req (ram_req),
		.ram_en  (ram_en),
		.rword   (rword)
	);

	// ==============================
	// response cycle
	// ==============================

	// lane pick and extension
	dm_load_align u_align (
		.rst        (rst),
		.rword      (rword),
		.tag        (tag),
		.tag_valid  (tag_valid),
		.resp       (resp),
		.resp_valid (resp_valid)
	);

endmodule

/* tb/dm_chk.sv */
`timescale 1ns/100ps

module dm_chk (
	input logic                clk,
	input logic                rst,
	input dm_pkg::dm_req_t     req,
	input logic                req_valid,
	input dm_pkg::dm_ram_req_t ram_req,
	input dm_pkg::dm_lane_t    tag,
	input logic                tag_valid,
	input logic                resp_valid
);

	// tag lines up with the RAM read word, one cycle after the strobe
	a_tag_after_strobe: assert property (@(posedge clk) disable iff (rst)
		req_valid |=> tag_valid)
		else $error("tag_valid missing one cycle after a strobe");

	a_tag_no_strobe: assert property (@(posedge clk) disable iff (rst)
		!req_valid |=> !tag_valid)
		else $error("tag_valid high without a strobe one cycle earlier");

	// any set enable needs a write strobe now and a legal access in the tag
	a_be_gated: assert property (@(posedge clk) disable iff (rst)
		(ram_req.be != 4'b0000) |-> (req_valid && req.we) ##1 tag.ok)
		else $error("byte enables set for a request that must not store");

	// a reset cycle leaves no response behind it, the tag register is cleared
	a_quiet_in_reset: assert property (@(posedge clk) rst |=> !resp_valid)
		else $error("resp_valid high during reset");

endmodule

// the top level holds both the check stage and the load side
bind dm dm_chk u_chk (
	.clk        (clk),
	.rst        (rst),
	.req        (req),
	.req_valid  (req_valid),
	.ram_req    (ram_req),
	.tag        (tag),
	.tag_valid  (tag_valid),
	.resp_valid (resp_valid)
);

/* tb/dm_tb.sv */
`timescale 1ns/100ps
`include "dm_cfg.svh"

module dm_tb;
	import dm_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_REQ = 600;
	// at most four cycles per request, plus reset and some slack
	localparam int LIMIT_CYCLES = NUM_REQ * 4 + 8 + 40;

	logic     clk;
	logic     rst;
	dm_req_t  req;
	logic     req_valid;
	dm_resp_t resp;
	logic     resp_valid;

	// byte image of the whole window, starts at zero like the block RAM
	logic [7:0] ref_mem [`DM_WORDS*4];
	// expected responses, oldest first
	dm_resp_t exp_q [$];
	// a strobe went out on the previous falling edge
	logic strobed;
	int data_errs;
	int proto_errs;
	int checked;

	dm u_dut (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.req_valid  (req_valid),
		.resp       (resp),
		.resp_valid (resp_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// ==============================
	// watchdog
	// ==============================

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("watchdog expired, run still busy after %0d cycles", LIMIT_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	// ==============================
	// stimulus and reference model
	// ==============================

	// random request, addresses mostly in the first 64 bytes
	task automatic make_req(output dm_req_t r);
		int sel;
		sel = $urandom_range(0, 9);
		r.mode = dm_mode_e'($urandom_range(0, 5));
		r.we = $urandom_range(0, 1);
		r.wdata = $urandom;
		if (sel < 8) begin
			r.addr = $urandom_range(0, 63);
			// sel 6 and 7 keep the raw address, often misaligned
			if (sel < 6 && r.mode == mode_w) begin
				r.addr[1:0] = 2'b00;
			end else if (sel < 6 && r.mode inside {mode_h, mode_hu}) begin
				r.addr[0] = 1'b0;
			end
		end else if (sel == 8) begin
			// top edge of the window
			r.addr = `DM_ADDR_UB - $urandom_range(0, 15);
		end else begin
			r.addr = `DM_ADDR_UB + 1 + $urandom_range(0, 255);
		end
	endtask

	// expected response, then the store into the byte image
	task automatic model_apply(input dm_req_t r, output dm_resp_t e);
		logic [31:0] a;
		logic ok;
		int nbytes;
		a = r.addr;
		case (r.mode)
			mode_none: ok = 1'b1;
			mode_w: ok = (a <= `DM_ADDR_UB) && (a[1:0] == 2'b00);
			mode_h, mode_hu: ok = (a <= `DM_ADDR_UB) && !a[0];
			default: ok = (a <= `DM_ADDR_UB);
		endcase
		e.ok = ok;
		e.rdata = 32'h0000_0000;
		// load sees the bytes before this request's store
		if (ok) begin
			case (r.mode)
				mode_w: e.rdata = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
				mode_h: e.rdata = {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
				mode_hu: e.rdata = {16'h0000, ref_mem[a+1], ref_mem[a]};
				mode_b: e.rdata = {{24{ref_mem[a][7]}}, ref_mem[a]};
				mode_bu: e.rdata = {24'h00_0000, ref_mem[a]};
				default: e.rdata = 32'h0000_0000;
			endcase
		end
		// unsigned modes and none never store
		case (r.mode)
			mode_w: nbytes = 4;
			mode_h: nbytes = 2;
			mode_b: nbytes = 1;
			default: nbytes = 0;
		endcase
		if (ok && r.we) begin
			for (int i = 0; i < nbytes; i++) begin
				ref_mem[a+i] = r.wdata[8*i +: 8];
			end
		end
	endtask

	// ==============================
	// compare tasks
	// ==============================

	task automatic check_resp(input dm_resp_t got);
		dm_resp_t e;
		if (exp_q.size() == 0) begin
			proto_errs++;
			$display("response at %0t ns with no request outstanding", $time);
		end else begin
			e = exp_q.pop_front();
			checked++;
			if (got !== e) begin
				data_errs++;
				$display("[FAIL] %0t ns: got rdata %h ok %b, expected rdata %h ok %b",
					$time, got.rdata, got.ok, e.rdata, e.ok);
			end
		end
	endtask

	task automatic check_idle(input logic valid);
		if (valid !== 1'b0) begin
			proto_errs++;
			$display("resp_valid high at %0t ns without a request one cycle before", $time);
		end
	endtask

	// outputs are settled half a cycle after the rising edge
	task automatic sample_outputs();
		dm_resp_t dropped;
		if (strobed && resp_valid !== 1'b1) begin
			proto_errs++;
			$display("response missing one cycle after the request, at %0t ns", $time);
			if (exp_q.size() > 0) begin
				dropped = exp_q.pop_front();
				$display("the missing response should have been rdata %h ok %b",
					dropped.rdata, dropped.ok);
			end
		end else if (strobed) begin
			check_resp(resp);
		end else begin
			check_idle(resp_valid);
		end
	endtask

	// ==============================
	// main sequence
	// ==============================

	initial begin
		dm_req_t r;
		dm_resp_t e;
		int unsigned seed;
		int gap;
		rst = 1'b1;
		req = '0;
		req_valid = 1'b0;
		strobed = 1'b0;
		data_errs = 0;
		proto_errs = 0;
		checked = 0;
		seed = $urandom(79);
		foreach (ref_mem[i]) begin
			ref_mem[i] = 8'h00;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int n = 0; n < NUM_REQ; n++) begin
			// about half the strobes go back to back
			gap = $urandom_range(0, 1) ? 0 : $urandom_range(1, 3);
			repeat (gap) begin
				@(negedge clk);
				sample_outputs();
				req_valid = 1'b0;
				strobed = 1'b0;
			end
			@(negedge clk);
			sample_outputs();
			make_req(r);
			model_apply(r, e);
			exp_q.push_back(e);
			req = r;
			req_valid = 1'b1;
			strobed = 1'b1;
		end
		// drain the last response and one idle cycle
		repeat (2) begin
			@(negedge clk);
			sample_outputs();
			req_valid = 1'b0;
			strobed = 1'b0;
		end
		if (exp_q.size() != 0) begin
			proto_errs++;
			$display("%0d expected responses never arrived", exp_q.size());
		end
		$display("checked %0d responses: %0d data errors, %0d protocol errors",
			checked, data_errs, proto_errs);
		if (data_errs == 0 && proto_errs == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+verilog
verilog/dm_pkg.sv
verilog/dm_access_check.sv
verilog/dm_ram.sv
verilog/dm_load_align.sv
verilog/dm.sv
tb/dm_chk.sv
tb/dm_tb.sv

/* Bender.yml */
package:
  name: dm

export_include_dirs:
  - verilog

sources:
  - verilog/dm_pkg.sv
  - verilog/dm_access_check.sv
  - verilog/dm_ram.sv
  - verilog/dm_load_align.sv
  - verilog/dm.sv
  - target: test
    files:
      - tb/dm_chk.sv
      - tb/dm_tb.sv
